/* rtl/dds_synth_settings.svh */
`ifndef DDS_SYNTH_SETTINGS_SVH
`define DDS_SYNTH_SETTINGS_SVH

// frame lengths in bytes
`define FRAME_BYTES 15
`define SET_FREQ_BYTES 13
`define ENABLE_BYTES 4

// device identity, reported by get id and get config
`define DEVICE_ID 8'h01
`define DEVICE_TYPE 16'd6

`define MCLK_HZ 64'd270000000 // master clock of the synthesizer
`define MAX_MV 16'd3300

`define NUM_CHANNELS 4

`endif

/* rtl/dds_synth_pkg.sv */
`default_nettype none

`include "dds_synth_settings.svh"

package dds_synth_pkg;

    // one-byte queries, answered in the next frame
    typedef enum logic [7:0] {
        get_id     = 8'd0,
        get_config = 8'd1,
        get_status = 8'd2
    } query_op_e;

    // sub-opcodes after the group byte
    typedef enum logic [7:0] {
        set_frequency = 8'd2,
        enable_output = 8'd5
    } dds_op_e;

    localparam logic [7:0] DDS_GROUP = 8'd3;

    typedef struct packed {
        logic [`FRAME_BYTES*8-1:0] data; // last bit received in bit 0
        logic [7:0]                bit_count;
    } spi_frame_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr; // {enable select, channel}
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/spi_frame_shifter.sv */
`default_nettype none

`include "dds_synth_settings.svh"

module spi_frame_shifter (
    input  logic                       spi_clock,
    input  logic                       nreset,
    input  logic                       sck,
    input  logic                       ncs,
    input  logic                       mosi,
    output logic                       miso,
    input  logic [`FRAME_BYTES*8-1:0]  response,
    input  logic                       load_response,
    output dds_synth_pkg::spi_frame_t  frame,
    output logic                       frame_done
);
    localparam int FRAME_BITS = `FRAME_BYTES * 8;

    logic [1:0]            sck_sync;
    logic [1:0]            ncs_sync;
    logic [1:0]            mosi_sync;
    logic                  sck_prev;
    logic                  ncs_prev;
    logic                  sck_rise;
    logic                  sck_fall;
    logic                  ncs_rise;
    logic [7:0]            bit_count;
    logic [7:0]            last_count;
    logic [FRAME_BITS-1:0] rx_shift;
    logic [FRAME_BITS-1:0] tx_shift;

    always_ff @(posedge spi_clock) begin
        if (!nreset) begin
            sck_sync  <= 2'b00;
            ncs_sync  <= 2'b11; // bus idles deselected
            mosi_sync <= 2'b00;
            sck_prev  <= 1'b0;
            ncs_prev  <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            ncs_sync  <= {ncs_sync[0], ncs};
            mosi_sync <= {mosi_sync[0], mosi};
            sck_prev  <= sck_sync[1];
            ncs_prev  <= ncs_sync[1];
        end
    end

    // sck edges count only inside a frame
    assign sck_rise = sck_sync[1] & ~sck_prev & ~ncs_sync[1];
    assign sck_fall = ~sck_sync[1] & sck_prev & ~ncs_sync[1];
    assign ncs_rise = ncs_sync[1] & ~ncs_prev;

    always_ff @(posedge spi_clock) begin
        if (!nreset) begin
            bit_count  <= '0;
            last_count <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= ncs_rise;
            if (ncs_rise) begin
                last_count <= bit_count; // held for the decoder
                bit_count  <= '0;
            end else if (sck_rise) begin
                bit_count <= bit_count + 8'd1;
            end
        end
    end

    always_ff @(posedge spi_clock) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_sync[1]};
        end
    end

    always_ff @(posedge spi_clock) begin
        if (!nreset) begin
            tx_shift <= '0;
        end else if (load_response) begin
            tx_shift <= response;
        end else if (sck_fall) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0}; // mode 0, next bit after falling sck
        end
    end

    assign miso  = tx_shift[FRAME_BITS-1] & ~ncs_sync[1];
    assign frame = '{data: rx_shift, bit_count: last_count};

endmodule

`default_nettype wire

/* rtl/command_decoder.sv */
`default_nettype none

`include "dds_synth_settings.svh"

module command_decoder (
    input  logic                       spi_clock,
    input  logic                       nreset,
    input  dds_synth_pkg::spi_frame_t  frame,
    input  logic                       frame_done,
    output logic [`FRAME_BYTES*8-1:0]  response,
    output logic                       load_response,
    output dds_synth_pkg::wb_req_t     wb_req,
    input  dds_synth_pkg::wb_rsp_t     wb_rsp
);
    localparam int RESP_BITS     = `FRAME_BYTES * 8;
    localparam int QUERY_BITS    = 8;
    localparam int SET_FREQ_BITS = `SET_FREQ_BYTES * 8;
    localparam int ENABLE_BITS   = `ENABLE_BYTES * 8;

    localparam logic [15:0] LEVEL_METER_TYPE = 16'h0000;
    localparam logic [7:0]  MAX_ATTENUATOR   = 8'h00;

    typedef enum logic [1:0] {idle, write, read, respond} state_e;

    function automatic logic [15:0] le16(input logic [15:0] value);
        return {value[7:0], value[15:8]};
    endfunction

    function automatic logic [63:0] le64(input logic [63:0] value);
        logic [63:0] swapped;
        for (int i = 0; i < 8; i++) begin
            swapped[63-8*i -: 8] = value[8*i +: 8];
        end
        return swapped;
    endfunction

    localparam logic [RESP_BITS-1:0] CONFIG_RESPONSE = {
        le16(`DEVICE_TYPE), le16(LEVEL_METER_TYPE), le64(`MCLK_HZ), le16(`MAX_MV), MAX_ATTENUATOR
    };

    state_e                 state;
    logic                   wb_active;
    logic                   wb_we;
    logic [2:0]             wb_adr;
    logic [31:0]            wb_dat;
    logic                   freq_cmd;
    logic                   enable_cmd;
    logic                   status_query;
    logic [31:0]            tuning_code;
    logic [RESP_BITS-1:0]   query_response;

    assign freq_cmd = frame.bit_count == 8'(SET_FREQ_BITS)
        && frame.data[SET_FREQ_BITS-1 -: 8] == dds_synth_pkg::DDS_GROUP
        && frame.data[SET_FREQ_BITS-9 -: 8] == dds_synth_pkg::set_frequency;
    assign enable_cmd = frame.bit_count == 8'(ENABLE_BITS)
        && frame.data[ENABLE_BITS-1 -: 8] == dds_synth_pkg::DDS_GROUP
        && frame.data[ENABLE_BITS-9 -: 8] == dds_synth_pkg::enable_output;
    assign status_query = frame.bit_count == 8'(QUERY_BITS)
        && frame.data[7:0] == dds_synth_pkg::get_status;

    // code bytes arrive least significant first
    assign tuning_code = {frame.data[55:48], frame.data[63:56], frame.data[71:64], frame.data[79:72]};

    always_comb begin
        query_response = '0;
        if (frame.bit_count == 8'(QUERY_BITS)) begin
            case (dds_synth_pkg::query_op_e'(frame.data[7:0]))
                dds_synth_pkg::get_id:     query_response = {`DEVICE_ID, {(RESP_BITS-8){1'b0}}};
                dds_synth_pkg::get_config: query_response = CONFIG_RESPONSE;
                default:                   query_response = '0; // status comes from the bank
            endcase
        end
    end

    always_ff @(posedge spi_clock) begin
        if (!nreset) begin
            state         <= idle;
            wb_active     <= 1'b0;
            load_response <= 1'b0;
        end else begin
            load_response <= 1'b0;
            case (state)
                idle: begin
                    if (frame_done) begin
                        if (freq_cmd || enable_cmd) begin
                            wb_active <= 1'b1;
                            state     <= write;
                        end else if (status_query) begin
                            wb_active <= 1'b1;
                            state     <= read;
                        end else begin
                            state <= respond;
                        end
                    end
                end
                write, read: begin
                    if (wb_rsp.ack) begin
                        wb_active <= 1'b0;
                        state     <= respond;
                    end
                end
                default: begin
                    load_response <= 1'b1;
                    state         <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge spi_clock) begin
        if (state == idle && frame_done) begin
            wb_we    <= ~status_query;
            wb_adr   <= freq_cmd ? {1'b0, frame.data[81:80]} : {1'b1, frame.data[9:8]};
            wb_dat   <= freq_cmd ? tuning_code : {31'b0, frame.data[7:0] != 8'h00};
            response <= query_response;
        end else if (state == read && wb_rsp.ack) begin
            response <= {wb_rsp.dat[7:0], {(RESP_BITS-8){1'b0}}}; // enable mask
        end
    end

    assign wb_req = '{cyc: wb_active, stb: wb_active, we: wb_we, adr: wb_adr, dat: wb_dat};

endmodule

`default_nettype wire

/* rtl/dds_channel_bank.sv */
`default_nettype none

`include "dds_synth_settings.svh"

module dds_channel_bank (
    input  logic                    spi_clock,
    input  logic                    nreset,
    input  dds_synth_pkg::wb_req_t  wb_req,
    output dds_synth_pkg::wb_rsp_t  wb_rsp,
    output logic [3:0]              out
);
    logic [31:0]              code [`NUM_CHANNELS];
    logic [31:0]              phase [`NUM_CHANNELS];
    logic [`NUM_CHANNELS-1:0] enable;
    logic                     ack;
    logic [31:0]              rd_data;
    logic                     access;
    logic [1:0]               channel;
    logic                     sel_enable;

    // one ack per request, even if stb stays high
    assign access     = wb_req.cyc & wb_req.stb & ~ack;
    assign channel    = wb_req.adr[1:0];
    assign sel_enable = wb_req.adr[2];

    always_ff @(posedge spi_clock) begin
        if (!nreset) begin
            ack    <= 1'b0;
            enable <= '0;
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                code[i] <= '0;
            end
        end else begin
            ack <= access;
            if (access && wb_req.we) begin
                if (sel_enable) begin
                    enable[channel] <= wb_req.dat[0];
                end else begin
                    code[channel] <= wb_req.dat;
                end
            end
        end
    end

    always_ff @(posedge spi_clock) begin
        if (access) begin
            rd_data <= sel_enable ? {{(32-`NUM_CHANNELS){1'b0}}, enable} : code[channel];
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_data};

    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_channel
        always_ff @(posedge spi_clock) begin
            if (!nreset) begin
                phase[i] <= '0;
            end else if (!enable[i]) begin
                phase[i] <= '0; // parked at zero while off
            end else begin
                phase[i] <= phase[i] + code[i];
            end
        end

        assign out[i] = phase[i][31];
    end

endmodule

`default_nettype wire

/* rtl/dds_synth.sv */
`default_nettype none

`include "dds_synth_settings.svh"

module dds_synth (
    input  logic       spi_clock,
    input  logic       nreset,
    input  logic       sck,
    input  logic       ncs,
    input  logic       mosi,
    output logic       miso,
    output logic [3:0] out
);
    dds_synth_pkg::spi_frame_t       frame;
    logic                            frame_done;
    logic [`FRAME_BYTES*8-1:0]       response;
    logic                            load_response;
    dds_synth_pkg::wb_req_t          wb_req;
    dds_synth_pkg::wb_rsp_t          wb_rsp;

    spi_frame_shifter shifter (
        .spi_clock     (spi_clock),
        .nreset        (nreset),
        .sck           (sck),
        .ncs           (ncs),
        .mosi          (mosi),
        .miso          (miso),
        .response      (response),
        .load_response (load_response),
        .frame         (frame),
        .frame_done    (frame_done)
    );

    command_decoder decoder (
        .spi_clock     (spi_clock),
        .nreset        (nreset),
        .frame         (frame),
        .frame_done    (frame_done),
        .response      (response),
        .load_response (load_response),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp)
    );

    dds_channel_bank bank (
        .spi_clock (spi_clock),
        .nreset    (nreset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .out       (out)
    );

endmodule

`default_nettype wire

/* dv/dds_synth_props.sv */
`default_nettype none

module dds_synth_props (
    input logic                   spi_clock,
    input logic                   nreset,
    input dds_synth_pkg::wb_req_t wb_req,
    input dds_synth_pkg::wb_rsp_t wb_rsp,
    input logic                   frame_done
);
    timeunit 1ns;
    timeprecision 100ps;

    ack_after_stb: assert property (@(posedge spi_clock) disable iff (!nreset)
        wb_req.cyc && wb_req.stb && !wb_rsp.ack |=> wb_rsp.ack)
        else $error("ack did not follow stb by one cycle");

    stb_holds: assert property (@(posedge spi_clock) disable iff (!nreset)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb)
        else $error("stb dropped before ack");

    ack_single: assert property (@(posedge spi_clock) disable iff (!nreset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack stayed high for more than one cycle");

    // master ends the cycle right after ack
    stb_drops: assert property (@(posedge spi_clock) disable iff (!nreset)
        wb_rsp.ack |=> !wb_req.stb)
        else $error("stb still high in the cycle after ack");

    frame_done_pulse: assert property (@(posedge spi_clock) disable iff (!nreset)
        frame_done |=> !frame_done)
        else $error("frame_done lasted more than one cycle");

endmodule

bind command_decoder dds_synth_props decoder_props (
    .spi_clock  (spi_clock),
    .nreset     (nreset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .frame_done (frame_done)
);

`default_nettype wire

/* dv/dds_synth_tb.sv */
`default_nettype none

`include "dds_synth_settings.svh"

module dds_synth_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESP_BYTES      = `FRAME_BYTES;
    localparam int HALF_SCK        = 8;
    localparam int FRAME_GAP       = 50;
    localparam int CYCLES_PER_LINE = 2500;
    localparam int WINDOW          = 256;
    localparam int SETTLE          = 40;
    localparam string STIMULUS_FILE = "dv/dds_synth_stimulus.txt";

    logic       spi_clock;
    logic       nreset;
    logic       sck;
    logic       ncs;
    logic       mosi;
    logic       miso;
    logic [3:0] out;

    integer     seed;
    int         error_count;
    int         check_count;
    int         cycle_count;
    int         cycle_limit;
    int         frame_count;
    logic [7:0] tx_bytes [RESP_BYTES];
    logic [7:0] rx_bytes [RESP_BYTES];

    dds_synth dut (
        .spi_clock (spi_clock),
        .nreset    (nreset),
        .sck       (sck),
        .ncs       (ncs),
        .mosi      (mosi),
        .miso      (miso),
        .out       (out)
    );

    always #50 spi_clock = ~spi_clock;

    always @(posedge spi_clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
            error_count++;
            finish_run();
        end
    end

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // one frame, MSB first, miso sampled just before each rising sck
    task automatic spi_transfer(input int nbytes);
        for (int i = 0; i < RESP_BYTES; i++) begin
            rx_bytes[i] = 8'h00;
        end
        @(negedge spi_clock);
        ncs = 1'b0;
        repeat (HALF_SCK) @(negedge spi_clock);
        for (int i = 0; i < nbytes; i++) begin
            for (int b = 7; b >= 0; b--) begin
                mosi = tx_bytes[i][b];
                repeat (HALF_SCK) @(negedge spi_clock);
                rx_bytes[i][b] = miso;
                sck = 1'b1;
                repeat (HALF_SCK) @(negedge spi_clock);
                sck = 1'b0;
            end
        end
        repeat (HALF_SCK) @(negedge spi_clock);
        ncs  = 1'b1;
        mosi = 1'b0;
        repeat (FRAME_GAP) @(negedge spi_clock);
    endtask

    task automatic run_frame_line(input int fd);
        int         nbytes;
        int         given;
        int         nexp;
        int         value;
        logic [7:0] expected [RESP_BYTES];
        if ($fscanf(fd, "%d %d", nbytes, given) != 2) begin
            $display("stimulus file has a frame line without its length fields");
            error_count++;
        end else begin
            for (int i = 0; i < RESP_BYTES; i++) begin
                tx_bytes[i] = 8'($random(seed)); // reserved bytes
                expected[i] = 8'h00;
            end
            for (int i = 0; i < given; i++) begin
                void'($fscanf(fd, "%h", value));
                tx_bytes[i] = value[7:0];
            end
            void'($fscanf(fd, "%d", nexp));
            for (int i = 0; i < nexp; i++) begin
                void'($fscanf(fd, "%h", value));
                expected[i] = value[7:0];
            end
            frame_count++;
            spi_transfer(nbytes);
            for (int i = 0; i < RESP_BYTES; i++) begin
                tx_bytes[i] = 8'h00;
            end
            spi_transfer(RESP_BYTES); // answer comes out during this one
            for (int i = 0; i < RESP_BYTES; i++) begin
                check_count++;
                if (rx_bytes[i] !== expected[i]) begin
                    $display("ERROR: miso byte %0d after frame %0d expected %h got %h",
                        i, frame_count, expected[i], rx_bytes[i]);
                    error_count++;
                end
            end
        end
    endtask

    task automatic check_period(input int fd);
        int   channel;
        int   period;
        int   rises;
        int   expected_rises;
        logic prev;
        void'($fscanf(fd, "%d %d", channel, period));
        repeat (SETTLE) @(negedge spi_clock);
        prev  = out[channel];
        rises = 0;
        repeat (WINDOW) begin
            @(negedge spi_clock);
            if (out[channel] && !prev) begin
                rises++;
            end
            prev = out[channel];
        end
        expected_rises = (period == 0) ? 0 : WINDOW / period;
        check_count++;
        if (rises != expected_rises) begin
            $display("ERROR: out[%0d] rising edges expected %h got %h",
                channel, expected_rises, rises);
            error_count++;
        end
        if (period == 0 && out[channel] !== 1'b0) begin
            $display("ERROR: out[%0d] expected %h got %h", channel, 1'b0, out[channel]);
            error_count++;
        end
    endtask

    task automatic run_stimulus(input int fd);
        int    kind;
        string rest;
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "f") begin
                run_frame_line(fd);
            end else if (kind == "p") begin
                check_period(fd);
            end else begin
                void'($fgets(rest, fd)); // comment line
            end
        end
    endtask

    initial begin
        int    fd;
        int    lines;
        string text;
        spi_clock   = 1'b0;
        nreset      = 1'b0;
        sck         = 1'b0;
        ncs         = 1'b1;
        mosi        = 1'b0;
        seed        = 82;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        frame_count = 0;
        lines       = 0;
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIMULUS_FILE);
            error_count++;
            finish_run();
        end else begin
            while ($fgets(text, fd) > 0) begin
                if (text.len() > 0 && (text[0] == "f" || text[0] == "p")) begin
                    lines++;
                end
            end
            $fclose(fd);
            cycle_limit = lines * CYCLES_PER_LINE;
            repeat (5) @(negedge spi_clock);
            nreset = 1'b1;
            repeat (200) begin
                @(negedge spi_clock);
                check_count++;
                if (out !== 4'h0) begin
                    $display("ERROR: out after reset expected %h got %h", 4'h0, out);
                    error_count++;
                end
                if (miso !== 1'b0) begin
                    $display("ERROR: miso after reset expected %h got %h", 1'b0, miso);
                    error_count++;
                end
            end
            fd = $fopen(STIMULUS_FILE, "r");
            run_stimulus(fd);
            $fclose(fd);
            finish_run();
        end
    end

endmodule

`default_nettype wire

/* dds_synth.f */
+incdir+rtl
rtl/dds_synth_pkg.sv
rtl/spi_frame_shifter.sv
rtl/command_decoder.sv
rtl/dds_channel_bank.sv
rtl/dds_synth.sv
dv/dds_synth_props.sv
dv/dds_synth_tb.sv

/* dv/dds_synth_stimulus.txt */
# f nbytes ngiven byte... nexp response_byte...  (missing frame bytes random, missing response bytes 00)
# p channel period  (period in spi_clock cycles, 0 for a constant low output)
f 1 1 02 1 00
f 1 1 00 1 01
f 1 1 01 15 06 00 00 00 80 df 17 10 00 00 00 00 e4 0c 00
f 13 7 03 02 00 00 00 00 80 0
p 0 0
f 4 4 03 05 00 01 0
p 0 2
f 13 7 03 02 01 00 00 00 40 0
f 4 4 03 05 01 ff 0
p 1 4
p 0 2
f 1 1 02 1 03
f 13 7 03 02 00 00 00 00 20 0
p 0 8
p 1 4
p 2 0
p 3 0
f 13 7 03 02 03 00 00 00 08 0
f 4 4 03 05 03 01 0
p 3 32
f 4 4 03 05 01 00 0
p 1 0
f 1 1 02 1 09
f 4 4 03 05 01 80 0
p 1 4
f 1 1 02 1 0b
f 12 7 03 02 00 00 00 00 80 0
f 13 7 03 07 00 00 00 00 80 0
p 0 8
f 4 4 04 05 02 01 0
f 3 3 03 05 02 0
p 2 0
f 1 1 09 0
f 2 2 00 00 0
f 1 1 02 1 0b
